//--- logic/uart_pkg.sv
package uart_pkg;

	// Line settings used when the top level does not override them.
	parameter int DEFAULT_CLOCK_FREQ = 10000000;
	parameter int DEFAULT_BAUD_RATE = 9600;

	// Payload bits per character, no parity.
	parameter int DATA_BITS = 8;

endpackage

//--- logic/cmd_pkg.sv
package cmd_pkg;

	parameter int ACC_WIDTH = 8;

	// Opcode byte of a command frame. Values not listed are invalid.
	typedef enum logic [7:0] {
		LOAD = 8'h01,
		ADD = 8'h02,
		SUB = 8'h03,
		AND = 8'h04,
		OR = 8'h05,
		XOR = 8'h06,
		READ = 8'h07 // Operand ignored.
	} op_t;

endpackage

//--- logic/uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver import uart_pkg::*; #(
	parameter int CLOCK_FREQ = DEFAULT_CLOCK_FREQ,
	parameter int BAUD_RATE = DEFAULT_BAUD_RATE
) (
	input logic clk,
	input logic nRst,
	input logic enable,
	input logic rx,
	output logic [DATA_BITS-1:0] data,
	output logic ready
);

	localparam int CYCLES_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W = $clog2(CYCLES_PER_BIT);
	localparam logic [3:0] STOP_SLOT = 4'(DATA_BITS + 1);

	logic receiving;
	logic [3:0] bit_cnt;
	logic [CNT_W-1:0] baud_cnt;
	logic [DATA_BITS-1:0] shift_reg;
	logic half_tick;
	logic bit_tick;

	// Middle of the start bit.
	assign half_tick = receiving && (bit_cnt == 4'd0) &&
		(baud_cnt == CNT_W'(CYCLES_PER_BIT / 2 - 1));

	// Middle of a data bit or of the stop slot.
	assign bit_tick = receiving && (bit_cnt != 4'd0) &&
		(baud_cnt == CNT_W'(CYCLES_PER_BIT - 1));

	// Baud counter only runs during a character.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			baud_cnt <= '0;
		end else if (!enable || !receiving || half_tick || bit_tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			receiving <= 1'b0;
			bit_cnt <= '0;
			data <= '0;
			ready <= 1'b0;
		end else if (!enable) begin
			receiving <= 1'b0;
			bit_cnt <= '0;
			data <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			if (!receiving) begin
				if (!rx) begin
					receiving <= 1'b1; // Falling edge may be a start bit.
					bit_cnt <= '0;
				end
			end else if (half_tick) begin
				if (rx) begin
					receiving <= 1'b0; // Line back high means a glitch.
				end else begin
					bit_cnt <= 4'd1;
				end
			end else if (bit_tick) begin
				if (bit_cnt == STOP_SLOT) begin
					data <= shift_reg;
					ready <= 1'b1;
					receiving <= 1'b0;
					bit_cnt <= '0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// LSB arrives first and ends up at bit 0.
	always_ff @(posedge clk) begin
		if (bit_tick && (bit_cnt != STOP_SLOT)) begin
			shift_reg <= {rx, shift_reg[DATA_BITS-1:1]};
		end
	end

endmodule

//--- logic/cmd_decoder.sv
`timescale 1ns/10ps

module cmd_decoder import cmd_pkg::*; (
	input logic clk,
	input logic nRst,
	input logic enable,
	input logic [7:0] rx_data,
	input logic rx_ready,
	output op_t cmd_op,
	output logic [7:0] cmd_operand,
	output logic cmd_valid
);

	typedef enum logic {
		WAIT_OP,
		WAIT_ARG
	} state_t;

	state_t state;
	logic [7:0] op_byte;

	function automatic logic is_valid_op(input logic [7:0] code);
		case (code)
			LOAD, ADD, SUB, AND, OR, XOR, READ: is_valid_op = 1'b1;
			default: is_valid_op = 1'b0;
		endcase
	endfunction

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= WAIT_OP;
			cmd_valid <= 1'b0;
		end else if (!enable) begin
			state <= WAIT_OP; // Half a frame is thrown away.
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			if (rx_ready) begin
				case (state)
					WAIT_OP: state <= WAIT_ARG;
					WAIT_ARG: begin
						state <= WAIT_OP;
						cmd_valid <= is_valid_op(op_byte); // Bad opcode, no pulse.
					end
					default: state <= WAIT_OP;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_ready && (state == WAIT_OP)) begin
			op_byte <= rx_data;
		end
		if (rx_ready && (state == WAIT_ARG)) begin
			cmd_op <= op_t'(op_byte);
			cmd_operand <= rx_data;
		end
	end

endmodule

//--- logic/cmd_executor.sv
`timescale 1ns/10ps

module cmd_executor import cmd_pkg::*; (
	input logic clk,
	input logic nRst,
	input op_t cmd_op,
	input logic [ACC_WIDTH-1:0] cmd_operand,
	input logic cmd_valid,
	output logic [ACC_WIDTH-1:0] result,
	output logic result_valid
);

	logic [ACC_WIDTH-1:0] acc;
	logic [ACC_WIDTH-1:0] next_acc;

	// Sums and differences drop the carry, so they wrap.
	always_comb begin
		case (cmd_op)
			LOAD: next_acc = cmd_operand;
			ADD: next_acc = acc + cmd_operand;
			SUB: next_acc = acc - cmd_operand;
			AND: next_acc = acc & cmd_operand;
			OR: next_acc = acc | cmd_operand;
			XOR: next_acc = acc ^ cmd_operand;
			READ: next_acc = acc;
			default: next_acc = acc;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= cmd_valid;
			if (cmd_valid) begin
				acc <= next_acc;
			end
		end
	end

	assign result = acc; // Reply always carries the new value.

endmodule

//--- logic/uart_transmitter.sv
`timescale 1ns/10ps

module uart_transmitter import uart_pkg::*; #(
	parameter int CLOCK_FREQ = DEFAULT_CLOCK_FREQ,
	parameter int BAUD_RATE = DEFAULT_BAUD_RATE
) (
	input logic clk,
	input logic nRst,
	input logic [DATA_BITS-1:0] data,
	input logic start,
	output logic tx,
	output logic busy
);

	localparam int CYCLES_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W = $clog2(CYCLES_PER_BIT);
	localparam logic [3:0] STOP_SLOT = 4'(DATA_BITS + 1);

	logic [CNT_W-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [DATA_BITS:0] shift_reg;
	logic bit_done;

	assign bit_done = busy && (baud_cnt == CNT_W'(CYCLES_PER_BIT - 1));

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			baud_cnt <= '0;
		end else if (!busy || bit_done) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			tx <= 1'b1;
			busy <= 1'b0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (start) begin
				tx <= 1'b0; // Start bit goes out at once.
				busy <= 1'b1;
				bit_cnt <= '0;
			end
		end else if (bit_done) begin
			if (bit_cnt == STOP_SLOT) begin
				busy <= 1'b0; // End of the stop bit.
				tx <= 1'b1;
			end else begin
				tx <= shift_reg[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Data bits LSB first, then the stop bit shifted in from the top.
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			shift_reg <= {1'b1, data};
		end else if (bit_done && (bit_cnt != STOP_SLOT)) begin
			shift_reg <= {1'b1, shift_reg[DATA_BITS:1]};
		end
	end

endmodule

//--- logic/uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top import uart_pkg::*, cmd_pkg::*; #(
	parameter int CLOCK_FREQ = DEFAULT_CLOCK_FREQ,
	parameter int BAUD_RATE = DEFAULT_BAUD_RATE
) (
	input logic clk,
	input logic nRst,
	input logic enable,
	input logic rx,
	output logic tx,
	output logic busy
);

	logic [7:0] rx_data;
	logic rx_ready;
	op_t cmd_op;
	logic [7:0] cmd_operand;
	logic cmd_valid;
	logic [7:0] result;
	logic result_valid;

	uart_receiver #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE(BAUD_RATE)
	) u_receiver (
		.clk(clk),
		.nRst(nRst),
		.enable(enable),
		.rx(rx),
		.data(rx_data),
		.ready(rx_ready)
	);

	cmd_decoder u_decoder (
		.clk(clk),
		.nRst(nRst),
		.enable(enable),
		.rx_data(rx_data),
		.rx_ready(rx_ready),
		.cmd_op(cmd_op),
		.cmd_operand(cmd_operand),
		.cmd_valid(cmd_valid)
	);

	cmd_executor u_executor (
		.clk(clk),
		.nRst(nRst),
		.cmd_op(cmd_op),
		.cmd_operand(cmd_operand),
		.cmd_valid(cmd_valid),
		.result(result),
		.result_valid(result_valid)
	);

	// Reply is sent without a handshake, frames are longer than replies.
	uart_transmitter #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE(BAUD_RATE)
	) u_transmitter (
		.clk(clk),
		.nRst(nRst),
		.data(result),
		.start(result_valid),
		.tx(tx),
		.busy(busy)
	);

endmodule

//--- test/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic nRst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		nRst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		nRst <= 1'b1; // Released on a rising edge.
	end

endmodule

//--- test/tb_uart_cmd.sv
`timescale 1ns/10ps

module tb_uart_cmd;

	localparam int CLOCK_FREQ = 1600000;
	localparam int BAUD_RATE = 100000;
	localparam int BIT_CYCLES = CLOCK_FREQ / BAUD_RATE;
	localparam int QUIET_BITS = 30;
	localparam int BITS_PER_LINE = 60;

	logic clk;
	logic nRst;
	logic enable;
	logic rx;
	logic tx;
	logic busy;

	logic [7:0] vec_op[$];
	logic [7:0] vec_arg[$];
	logic [7:0] vec_flag[$];
	logic [7:0] vec_exp[$];
	logic [7:0] replies[$];
	logic [7:0] model_acc = 8'h00;
	integer seed = 35;
	int cycle = 0;
	int cycle_limit = 0;
	int last_drive = 0;
	int busy_cycles = 0;
	int busy_pulses = 0;
	int rise_cycle = 0;

	clock_gen clocks (.clk(clk), .nRst(nRst));

	uart_cmd_top #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE(BAUD_RATE)
	) UUT (
		.clk(clk),
		.nRst(nRst),
		.enable(enable),
		.rx(rx),
		.tx(tx),
		.busy(busy)
	);

	task automatic abort_run(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Accumulator after one command, byte arithmetic modulo 256.
	function automatic logic [7:0] predict_acc(input logic [7:0] code, input logic [7:0] arg,
		input logic [7:0] acc);
		case (code)
			8'h01: return arg;
			8'h02: return 8'((int'(acc) + int'(arg)) % 256);
			8'h03: return 8'((int'(acc) - int'(arg) + 256) % 256);
			8'h04: return acc & arg;
			8'h05: return acc | arg;
			8'h06: return acc ^ arg;
			default: return acc; // READ and unknown codes.
		endcase
	endfunction

	task automatic load_vectors();
		int fd;
		int got;
		string line;
		logic [7:0] f_op, f_arg, f_flag, f_exp;
		fd = $fopen("test/uart_cmd_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file test/uart_cmd_input.txt");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if ((got > 0) && (line[0] != "#")) begin
					got = $sscanf(line, "%h %h %h %h", f_op, f_arg, f_flag, f_exp);
					if (got == 4) begin
						vec_op.push_back(f_op);
						vec_arg.push_back(f_arg);
						vec_flag.push_back(f_flag);
						vec_exp.push_back(f_exp);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_bit(input logic value);
		@(posedge clk);
		last_drive = cycle;
		rx <= value;
		repeat (BIT_CYCLES - 1) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] value);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(value[i]);
		end
		drive_bit(1'b1);
		drive_bit(1'b1); // Two idle bits follow.
		drive_bit(1'b1);
	endtask

	// Start bit and three data bits, then enable drops with the line idle.
	task automatic send_cut_byte(input logic [7:0] value);
		drive_bit(1'b0);
		for (int i = 0; i < 3; i++) begin
			drive_bit(value[i]);
		end
		@(posedge clk);
		rx <= 1'b1;
		enable <= 1'b0;
		repeat (2 * BIT_CYCLES) @(posedge clk);
		enable <= 1'b1;
		repeat (2 * BIT_CYCLES) @(posedge clk);
	endtask

	task automatic capture_byte(output logic [7:0] value);
		@(negedge tx);
		repeat (BIT_CYCLES / 2) @(negedge clk);
		assert (tx == 1'b0) else abort_run("start bit on tx shorter than half a bit");
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CYCLES) @(negedge clk);
			value[i] = tx;
		end
		repeat (BIT_CYCLES) @(negedge clk);
		assert (tx == 1'b1) else abort_run("stop bit missing on tx");
	endtask

	task automatic wait_reply(output logic [7:0] value);
		int waited;
		waited = 0;
		while ((replies.size() == 0) && (waited < QUIET_BITS * BIT_CYCLES)) begin
			@(negedge clk);
			waited++;
		end
		assert (replies.size() != 0) else
			abort_run($sformatf("no reply on tx within %0d bit times", QUIET_BITS));
		value = replies.pop_front();
	endtask

	task automatic expect_silence(input int pulses_before);
		repeat (QUIET_BITS * BIT_CYCLES) @(negedge clk);
		assert ((replies.size() == 0) && (busy_pulses == pulses_before)) else
			abort_run("a reply was sent for a frame that must be dropped");
	endtask

	task automatic run_frame(input int idx);
		logic [7:0] code;
		logic [7:0] arg;
		logic [7:0] flag;
		logic [7:0] expected;
		logic [7:0] reply;
		int stop_at;
		int pulses_before;
		code = vec_op[idx];
		arg = vec_arg[idx];
		flag = vec_flag[idx];
		if (flag == 8'h02) begin
			arg = 8'($random(seed));
		end
		pulses_before = busy_pulses;
		assert (busy == 1'b0) else abort_run("busy high at the start of a frame");
		send_byte(code);
		if (flag == 8'h03) begin
			send_cut_byte(arg);
			expect_silence(pulses_before); // Accumulator keeps its value.
		end else if (flag == 8'h00) begin
			send_byte(arg);
			expect_silence(pulses_before);
		end else begin
			send_byte(arg);
			stop_at = last_drive - 2 * BIT_CYCLES; // Cycle the stop bit went out.
			model_acc = predict_acc(code, arg, model_acc);
			expected = model_acc;
			if (flag == 8'h01) begin
				assert (model_acc == vec_exp[idx]) else
					abort_run($sformatf("line %0d of the stimulus disagrees with the rules", idx));
				expected = vec_exp[idx];
			end
			wait_reply(reply);
			assert (reply == expected) else
				abort_run($sformatf("op %h arg %h gave reply %h, expected %h",
					code, arg, reply, expected));
			while (busy) @(negedge clk);
			assert ((busy_pulses == pulses_before + 1) && (rise_cycle > stop_at)) else
				abort_run("busy did not rise once after the operand stop bit");
		end
	endtask

	// Cycle count and run limit.
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if ((cycle_limit != 0) && (cycle >= cycle_limit)) begin
			$display("Run did not finish within %0d clock cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// Each reply holds busy for ten bit times.
	always @(posedge clk) begin
		if (busy) begin
			if (busy_cycles == 0) begin
				rise_cycle = cycle;
				busy_pulses = busy_pulses + 1;
			end
			busy_cycles = busy_cycles + 1;
		end else if (busy_cycles != 0) begin
			assert (busy_cycles == 10 * BIT_CYCLES) else
				abort_run($sformatf("busy high for %0d cycles, expected %0d",
					busy_cycles, 10 * BIT_CYCLES));
			busy_cycles = 0;
		end
	end

	initial begin
		logic [7:0] value;
		@(posedge nRst);
		forever begin
			capture_byte(value);
			replies.push_back(value);
		end
	end

	initial begin
		rx = 1'b1;
		enable = 1'b1;
		load_vectors();
		cycle_limit = vec_op.size() * BITS_PER_LINE * BIT_CYCLES + 1000;
		@(posedge nRst);
		repeat (4 * BIT_CYCLES) begin
			@(negedge clk);
			assert ((tx == 1'b1) && (busy == 1'b0)) else abort_run("tx or busy not idle after reset");
		end
		for (int i = 0; i < vec_op.size(); i++) begin
			run_frame(i);
		end
		repeat (2) @(negedge clk); // Let the busy monitor see the last fall.
		if ((vec_op.size() > 0) && (replies.size() == 0) && (busy_cycles == 0)) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("no frames were run or a reply was left unchecked");
		end
	end

endmodule

//--- files.f
logic/uart_pkg.sv
logic/cmd_pkg.sv
logic/uart_receiver.sv
logic/cmd_decoder.sv
logic/cmd_executor.sv
logic/uart_transmitter.sv
logic/uart_cmd_top.sv
test/clock_gen.sv
test/tb_uart_cmd.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_uart_cmd -f files.f -o sim_tb_uart_cmd \
	&& ./obj_dir/sim_tb_uart_cmd \
	|| exit 1

//--- test/uart_cmd_input.txt
# opcode operand flag expected, all hex
# flag 0 dropped frame, 1 reply equals expected, 2 random operand, 3 frame cut by enable
01 5a 1 5a
02 30 1 8a
03 9c 1 ee
04 3c 1 2c
05 41 1 6d
06 ff 1 92
07 00 1 92
00 12 0 00
0f 34 0 00
07 aa 1 92
02 00 2 00
03 00 2 00
04 00 2 00
05 00 2 00
06 00 2 00
01 c3 1 c3
01 77 3 00
07 00 1 c3
02 fe 1 c1
